// File: filelist.f
logic/packetmem_pkg.sv
logic/mem_port_if.sv
logic/p3_ctrl.sv
logic/buffer_router.sv
logic/packet_ram.sv
logic/read_size_adapter.sv
logic/packetmem.sv
verif/packetmem_tb.sv

// File: logic/buffer_router.sv
`timescale 1ns/1ps

module buffer_router #(
	parameter int ADDR_WIDTH = 10
) (
	input  packetmem_pkg::buf_owner_t          owner [packetmem_pkg::NUM_BUFS],
	input  logic [ADDR_WIDTH-1:0]              snooper_wr_addr,
	input  logic [packetmem_pkg::DATA_W-1:0]   snooper_wr_data,
	input  logic                               snooper_wr_en,
	input  logic [ADDR_WIDTH-1:0]              cpu_rd_addr, // Word address
	input  logic                               cpu_rd_en,
	input  logic [ADDR_WIDTH-1:0]              forwarder_rd_addr,
	input  logic                               forwarder_rd_en,
	output packetmem_pkg::mem_window_u         cpu_window,
	output logic [packetmem_pkg::LEN_W-1:0]    len_to_cpu,
	output packetmem_pkg::mem_window_u         forwarder_window,
	output logic [packetmem_pkg::LEN_W-1:0]    len_to_forwarder,
	mem_port_if.router                         ping,
	mem_port_if.router                         pang,
	mem_port_if.router                         pung
);
	import packetmem_pkg::*;

	buf_sel_t sn_sel, cpu_sel, fwd_sel;

	// Per-buffer views so the steering can loop
	logic [ADDR_WIDTH-1:0] addr_a [NUM_BUFS];
	logic [NUM_BUFS-1:0]   wr_en_a, rd_en_a;
	mem_window_u           win_a [NUM_BUFS];
	logic [LEN_W-1:0]      len_a [NUM_BUFS];

	// Which buffer each agent actively holds
	always_comb begin
		sn_sel = '0;
		cpu_sel = '0;
		fwd_sel = '0;
		for (int i = 0; i < NUM_BUFS; i++) begin
			if (owner[i] == own_sn)  sn_sel = buf_sel_t'(i + 1);
			if (owner[i] == own_cpu) cpu_sel = buf_sel_t'(i + 1);
			if (owner[i] == own_fwd) fwd_sel = buf_sel_t'(i + 1);
		end
	end

	always_comb begin
		cpu_window = '0; // Idle agents read zeros
		len_to_cpu = '0;
		forwarder_window = '0;
		len_to_forwarder = '0;
		for (int i = 0; i < NUM_BUFS; i++) begin
			wr_en_a[i] = snooper_wr_en && sn_sel == buf_sel_t'(i + 1);
			rd_en_a[i] = (cpu_rd_en && cpu_sel == buf_sel_t'(i + 1)) ||
				(forwarder_rd_en && fwd_sel == buf_sel_t'(i + 1));
			if (sn_sel == buf_sel_t'(i + 1))
				addr_a[i] = snooper_wr_addr;
			else if (fwd_sel == buf_sel_t'(i + 1))
				addr_a[i] = forwarder_rd_addr;
			else
				addr_a[i] = cpu_rd_addr; // Also parks free and waiting buffers
			if (cpu_sel == buf_sel_t'(i + 1)) begin
				cpu_window = win_a[i];
				len_to_cpu = len_a[i];
			end
			if (fwd_sel == buf_sel_t'(i + 1)) begin
				forwarder_window = win_a[i];
				len_to_forwarder = len_a[i];
			end
		end
		// Enables from agents without a buffer are dropped above
		a_idle_en: assert final (!(snooper_wr_en && sn_sel == '0) &&
			!(cpu_rd_en && cpu_sel == '0) && !(forwarder_rd_en && fwd_sel == '0));
	end

	assign ping.addr = addr_a[0];
	assign ping.wr_data = snooper_wr_data;
	assign ping.wr_en = wr_en_a[0];
	assign ping.rd_en = rd_en_a[0];
	assign pang.addr = addr_a[1];
	assign pang.wr_data = snooper_wr_data;
	assign pang.wr_en = wr_en_a[1];
	assign pang.rd_en = rd_en_a[1];
	assign pung.addr = addr_a[2];
	assign pung.wr_data = snooper_wr_data;
	assign pung.wr_en = wr_en_a[2];
	assign pung.rd_en = rd_en_a[2];

	assign win_a[0] = ping.rd_data;
	assign win_a[1] = pang.rd_data;
	assign win_a[2] = pung.rd_data;
	assign len_a[0] = ping.len;
	assign len_a[1] = pang.len;
	assign len_a[2] = pung.len;

endmodule

// File: logic/mem_port_if.sv
`timescale 1ns/1ps

// One buffer's access port, router on one side and RAM on the other
interface mem_port_if #(
	parameter int ADDR_WIDTH = 10
);
	import packetmem_pkg::*;

	logic [ADDR_WIDTH-1:0] addr;    // Word address, shared by reads and writes
	logic [DATA_W-1:0]     wr_data;
	logic                  wr_en;
	logic                  rd_en;
	mem_window_u           rd_data; // Registered window
	logic [LEN_W-1:0]      len;     // Words written so far

	modport router (
		output addr, wr_data, wr_en, rd_en,
		input  rd_data, len
	);

	modport ram (
		input  addr, wr_data, wr_en, rd_en,
		output rd_data, len
	);

endinterface

// File: logic/p3_ctrl.sv
`timescale 1ns/1ps

module p3_ctrl (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic                                   snooper_done,
	input  logic                                   cpu_acc,
	input  logic                                   cpu_rej,
	input  logic                                   forwarder_done,
	output packetmem_pkg::buf_owner_t              owner [packetmem_pkg::NUM_BUFS],
	output logic [packetmem_pkg::NUM_BUFS-1:0]     len_clr,
	output logic                                   ready_for_snooper,
	output logic                                   ready_for_cpu,
	output logic                                   ready_for_forwarder
);
	import packetmem_pkg::*;

	buf_owner_t owner_q [NUM_BUFS];
	buf_owner_t owner_d [NUM_BUFS];

	// One bit per buffer for each state of interest
	logic [NUM_BUFS-1:0] is_sn, is_cw, is_cpu, is_fw, is_fwd;
	logic rdy_sn_d, rdy_cpu_d, rdy_fwd_d;

	always_comb begin
		for (int i = 0; i < NUM_BUFS; i++) begin
			is_sn[i]   = owner_q[i] == own_sn;
			is_cw[i]   = owner_q[i] == own_cpu_wait;
			is_cpu[i]  = owner_q[i] == own_cpu;
			is_fw[i]   = owner_q[i] == own_fwd_wait;
			is_fwd[i]  = owner_q[i] == own_fwd;
		end
	end

	// Releases on agent pulses, grants to idle agents
	// Grants look only at the current state, so a released agent waits a cycle
	always_comb begin
		logic taken; // Snooper already given a buffer in this pass
		taken = 1'b0;
		owner_d = owner_q;
		for (int i = 0; i < NUM_BUFS; i++) begin
			case (owner_q[i])
				own_free: begin
					// Lowest free index first, held back while a packet waits for the CPU
					if (!(|is_sn) && !(|is_cw) && !taken) begin
						owner_d[i] = own_sn;
						taken = 1'b1;
					end
				end
				own_sn:       if (snooper_done) owner_d[i] = own_cpu_wait;
				own_cpu_wait: if (!(|is_cpu) && !(|is_fw)) owner_d[i] = own_cpu;
				own_cpu: begin
					if (cpu_acc)
						owner_d[i] = own_fwd_wait; // Accept wins over a stray reject
					else if (cpu_rej)
						owner_d[i] = own_free;
				end
				own_fwd_wait: if (!(|is_fwd)) owner_d[i] = own_fwd;
				own_fwd:      if (forwarder_done) owner_d[i] = own_free;
				default:      owner_d[i] = own_free; // Unused codes fall back to free
			endcase
		end
		rdy_sn_d = 1'b0;
		rdy_cpu_d = 1'b0;
		rdy_fwd_d = 1'b0;
		for (int i = 0; i < NUM_BUFS; i++) begin
			rdy_sn_d  |= owner_d[i] == own_sn;
			rdy_cpu_d |= owner_d[i] == own_cpu;
			rdy_fwd_d |= owner_d[i] == own_fwd;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_BUFS; i++)
				owner_q[i] <= own_free;
			ready_for_snooper <= 1'b0;
			ready_for_cpu <= 1'b0;
			ready_for_forwarder <= 1'b0;
		end else begin
			owner_q <= owner_d;
			ready_for_snooper <= rdy_sn_d;   // Ready mirrors ownership
			ready_for_cpu <= rdy_cpu_d;
			ready_for_forwarder <= rdy_fwd_d;
		end
	end

	// Length cleared whenever a buffer goes back to free
	always_comb begin
		for (int i = 0; i < NUM_BUFS; i++)
			len_clr[i] = rst || (is_cpu[i] && cpu_rej && !cpu_acc) ||
				(is_fwd[i] && forwarder_done);
	end

	assign owner = owner_q;

	a_acc_rej: assert property (@(posedge clk) disable iff (rst) !(cpu_acc && cpu_rej));

	// Pulses only from agents that were granted a buffer
	a_pulse_ready: assert property (@(posedge clk) disable iff (rst)
		(!snooper_done || ready_for_snooper) &&
		(!(cpu_acc || cpu_rej) || ready_for_cpu) &&
		(!forwarder_done || ready_for_forwarder));

	a_one_holder: assert property (@(posedge clk) disable iff (rst)
		$onehot0(is_sn) && $onehot0(is_cpu) && $onehot0(is_fwd));

endmodule

// File: logic/packet_ram.sv
`timescale 1ns/1ps

module packet_ram #(
	parameter int ADDR_WIDTH = 10
) (
	input  logic clk,
	input  logic len_clr, // Zeroes the word count
	mem_port_if.ram port
);
	import packetmem_pkg::*;

	logic [DATA_W-1:0]     mem [2**ADDR_WIDTH];
	logic [ADDR_WIDTH-1:0] addr_nxt;

	// Second window word, top address wraps to 0
	assign addr_nxt = port.addr + 1'b1;

	always_ff @(posedge clk) begin
		if (port.wr_en)
			mem[port.addr] <= port.wr_data;
		// Window holds until the next read
		if (port.rd_en) begin
			port.rd_data.words[0] <= mem[port.addr];
			port.rd_data.words[1] <= mem[addr_nxt];
		end
	end

	// Packet length is the number of words written
	always_ff @(posedge clk) begin
		if (len_clr)
			port.len <= '0;
		else if (port.wr_en)
			port.len <= port.len + 1'b1;
	end

	// A buffer being released is never being filled
	a_no_wr_on_clr: assert property (@(posedge clk) len_clr |-> !port.wr_en);

endmodule

// File: logic/packetmem.sv
`timescale 1ns/1ps

module packetmem #(
	parameter int ADDR_WIDTH = 10
) (
	input  logic                                   clk,
	input  logic                                   rst,

	// Snooper side
	input  logic [ADDR_WIDTH-1:0]                  snooper_wr_addr,
	input  logic [packetmem_pkg::DATA_W-1:0]       snooper_wr_data,
	input  logic                                   snooper_wr_en,
	input  logic                                   snooper_done, // 1-cycle pulse
	output logic                                   ready_for_snooper,

	// CPU side
	input  logic [ADDR_WIDTH+1:0]                  cpu_byte_rd_addr,
	input  logic [1:0]                             transfer_sz,
	output logic [packetmem_pkg::DATA_W-1:0]       cpu_rd_data,
	input  logic                                   cpu_rd_en,
	input  logic                                   cpu_rej,      // 1-cycle pulse
	input  logic                                   cpu_acc,      // 1-cycle pulse
	output logic                                   ready_for_cpu,
	output logic [packetmem_pkg::LEN_W-1:0]        len_to_cpu,

	// Forwarder side
	input  logic [ADDR_WIDTH-1:0]                  forwarder_rd_addr,
	output logic [2*packetmem_pkg::DATA_W-1:0]     forwarder_rd_data,
	input  logic                                   forwarder_rd_en,
	input  logic                                   forwarder_done, // 1-cycle pulse
	output logic                                   ready_for_forwarder,
	output logic [packetmem_pkg::LEN_W-1:0]        len_to_forwarder
);
	import packetmem_pkg::*;

	buf_owner_t            owner [NUM_BUFS];
	logic [NUM_BUFS-1:0]   len_clr;
	logic [ADDR_WIDTH-1:0] cpu_rd_addr; // Word address out of the adapter
	mem_window_u           cpu_window;

	mem_port_if #(.ADDR_WIDTH(ADDR_WIDTH)) ping_if ();
	mem_port_if #(.ADDR_WIDTH(ADDR_WIDTH)) pang_if ();
	mem_port_if #(.ADDR_WIDTH(ADDR_WIDTH)) pung_if ();

	p3_ctrl dispatcher (
		.clk(clk),
		.rst(rst),
		.snooper_done(snooper_done),
		.cpu_acc(cpu_acc),
		.cpu_rej(cpu_rej),
		.forwarder_done(forwarder_done),
		.owner(owner),
		.len_clr(len_clr),
		.ready_for_snooper(ready_for_snooper),
		.ready_for_cpu(ready_for_cpu),
		.ready_for_forwarder(ready_for_forwarder)
	);

	read_size_adapter #(.ADDR_WIDTH(ADDR_WIDTH)) cpu_adapter (
		.clk(clk),
		.byte_rd_addr(cpu_byte_rd_addr),
		.transfer_sz(xfer_size_t'(transfer_sz)),
		.word_rd_addr(cpu_rd_addr),
		.window(cpu_window),
		.resized_data(cpu_rd_data)
	);

	buffer_router #(.ADDR_WIDTH(ADDR_WIDTH)) router (
		.owner(owner),
		.snooper_wr_addr(snooper_wr_addr),
		.snooper_wr_data(snooper_wr_data),
		.snooper_wr_en(snooper_wr_en),
		.cpu_rd_addr(cpu_rd_addr),
		.cpu_rd_en(cpu_rd_en),
		.forwarder_rd_addr(forwarder_rd_addr),
		.forwarder_rd_en(forwarder_rd_en),
		.cpu_window(cpu_window),
		.len_to_cpu(len_to_cpu),
		.forwarder_window(forwarder_rd_data), // Word view goes out whole
		.len_to_forwarder(len_to_forwarder),
		.ping(ping_if.router),
		.pang(pang_if.router),
		.pung(pung_if.router)
	);

	packet_ram #(.ADDR_WIDTH(ADDR_WIDTH)) ping (
		.clk(clk), .len_clr(len_clr[0]), .port(ping_if.ram)
	);
	packet_ram #(.ADDR_WIDTH(ADDR_WIDTH)) pang (
		.clk(clk), .len_clr(len_clr[1]), .port(pang_if.ram)
	);
	packet_ram #(.ADDR_WIDTH(ADDR_WIDTH)) pung (
		.clk(clk), .len_clr(len_clr[2]), .port(pung_if.ram)
	);

endmodule

// File: logic/packetmem_pkg.sv
package packetmem_pkg;

	// Stored word and packet length widths
	localparam int DATA_W = 32;
	localparam int LEN_W = 32;

	// Rotation relies on exactly three buffers
	localparam int NUM_BUFS = 3;

	// Life cycle of one buffer
	typedef enum logic [2:0] {
		own_free     = 3'd0, // Empty, waiting for the snooper
		own_sn       = 3'd1, // Being filled
		own_cpu_wait = 3'd2, // Full, queued for the CPU
		own_cpu      = 3'd3, // CPU inspecting
		own_fwd_wait = 3'd4, // Accepted, queued for the forwarder
		own_fwd      = 3'd5  // Being forwarded
	} buf_owner_t;

	// Buffer held by an agent, 0 is none and 1..3 map to buffers 0..2
	typedef logic [1:0] buf_sel_t;

	// CPU access size
	typedef enum logic [1:0] {
		sz_byte = 2'd0,
		sz_half = 2'd1,
		sz_word = 2'd2 // Code 3 also served as a word
	} xfer_size_t;

	// Two-word read window
	// Word 0 sits at the addressed location, word 1 at the next one
	typedef union packed {
		logic [1:0][DATA_W-1:0] words; // Forwarder view
		logic [7:0][7:0]        bytes; // Byte 0 is the low byte of word 0
	} mem_window_u;

endpackage

// File: logic/read_size_adapter.sv
`timescale 1ns/1ps

module read_size_adapter #(
	parameter int ADDR_WIDTH = 10
) (
	input  logic                               clk,
	input  logic [ADDR_WIDTH+1:0]              byte_rd_addr,
	input  packetmem_pkg::xfer_size_t          transfer_sz,
	output logic [ADDR_WIDTH-1:0]              word_rd_addr,
	input  packetmem_pkg::mem_window_u         window,
	output logic [packetmem_pkg::DATA_W-1:0]   resized_data // Zero-padded on the left
);
	import packetmem_pkg::*;

	logic [1:0] offset_q; // Byte lane of the read in flight
	xfer_size_t size_q;
	logic [2:0] base;     // Offset widened so base+3 stays in the window

	assign word_rd_addr = byte_rd_addr[ADDR_WIDTH+1:2];

	// Tracks the RAM read latency
	always_ff @(posedge clk) begin
		offset_q <= byte_rd_addr[1:0];
		size_q <= transfer_sz;
	end

	assign base = {1'b0, offset_q};

	// Little-endian pick from the byte view, may spill into the next word
	always_comb begin
		resized_data = '0;
		case (size_q)
			sz_byte: resized_data[7:0] = window.bytes[base];
			sz_half: resized_data[15:0] = {window.bytes[base + 3'd1], window.bytes[base]};
			default: begin
				resized_data = {window.bytes[base + 3'd3], window.bytes[base + 3'd2],
					window.bytes[base + 3'd1], window.bytes[base]};
			end
		endcase
	end

endmodule

// File: verif/packetmem_tb.sv
`timescale 1ns/1ps

module packetmem_tb;
	import packetmem_pkg::*;

	localparam int AW = 6;
	localparam int TIMEOUT = 200; // Cycles allowed for any ready to rise

	logic                clk;
	logic                rst;
	logic [AW-1:0]       snooper_wr_addr;
	logic [DATA_W-1:0]   snooper_wr_data;
	logic                snooper_wr_en, snooper_done, ready_for_snooper;
	logic [AW+1:0]       cpu_byte_rd_addr;
	logic [1:0]          transfer_sz;
	logic [DATA_W-1:0]   cpu_rd_data;
	logic                cpu_rd_en, cpu_rej, cpu_acc, ready_for_cpu;
	logic [LEN_W-1:0]    len_to_cpu, len_to_forwarder;
	logic [AW-1:0]       forwarder_rd_addr;
	logic [2*DATA_W-1:0] forwarder_rd_data;
	logic                forwarder_rd_en, forwarder_done, ready_for_forwarder;

	// Packet model, one word list per packet in arrival order
	logic [DATA_W-1:0] pkt_data [8][16];
	int pkt_len [8];
	int num_pkts = 0;
	int cpu_q [$]; // Written, not yet seen by the CPU
	int fwd_q [$]; // Accepted, not yet forwarded
	logic [31:0] seed = 32'haa976d21;
	int errors = 0;
	int timeouts = 0;
	bit stalled = 1'b0; // Set once a ready never came

	// Expected read results, delayed to line up with the read latency
	logic [DATA_W-1:0] cpu_exp, cpu_exp_q;
	mem_window_u fwd_exp, fwd_exp_q;
	logic cpu_pend = 1'b0;
	logic fwd_pend = 1'b0;

	packetmem #(.ADDR_WIDTH(AW)) uut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// Little-endian bytes from the packet, zero-padded on the left
	function automatic logic [DATA_W-1:0] ref_cpu_read(int id, int addr, logic [1:0] sz);
		int nb;
		int b;
		int a;
		logic [7:0] b8;
		logic [DATA_W-1:0] res;
		nb = (sz == sz_byte) ? 1 : (sz == sz_half) ? 2 : 4; // Code 3 counts as a word
		res = '0;
		for (b = 0; b < nb; b++) begin
			a = addr + b;
			b8 = pkt_data[id][a / 4] >> (8 * (a % 4));
			res = res | (DATA_W'(b8) << (8 * b));
		end
		return res;
	endfunction

	function automatic mem_window_u ref_fwd_read(int id, int a);
		mem_window_u w;
		w.words[0] = pkt_data[id][a];     // Addressed word low
		w.words[1] = pkt_data[id][a + 1];
		return w;
	endfunction

	task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
			input logic [DATA_W-1:0] act);
		if (act !== exp) begin
			errors++;
			$display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_window(input string name, input mem_window_u exp, input mem_window_u act);
		if (act !== exp) begin
			errors++;
			$display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("ERR t=%0t %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	function automatic logic ready_of(int which);
		case (which)
			0:       return ready_for_snooper;
			1:       return ready_for_cpu;
			default: return ready_for_forwarder;
		endcase
	endfunction

	// Returns on the falling edge where the ready is seen high
	task automatic wait_ready(input int which);
		int n;
		string name;
		name = (which == 0) ? "ready_for_snooper" :
			(which == 1) ? "ready_for_cpu" : "ready_for_forwarder";
		if (stalled)
			return; // Run already broken, skip ahead to the report
		for (n = 0; n < TIMEOUT; n++) begin
			@(negedge clk);
			if (ready_of(which))
				return;
		end
		timeouts++;
		stalled = 1'b1;
		$display("Timeout: %s never went high within %0d cycles", name, TIMEOUT);
	endtask

	task automatic write_packet();
		int n;
		int id;
		int i;
		n = 4 + lcg_next() % 12;
		id = num_pkts;
		wait_ready(0);
		for (i = 0; i < n; i++) begin
			@(posedge clk);
			pkt_data[id][i] = lcg_next();
			snooper_wr_addr <= i[AW-1:0];
			snooper_wr_data <= pkt_data[id][i];
			snooper_wr_en <= 1'b1;
		end
		@(posedge clk);
		snooper_wr_en <= 1'b0;
		snooper_done <= 1'b1;
		@(posedge clk);
		snooper_done <= 1'b0;
		@(negedge clk);
		check_bit("ready_for_snooper", 1'b0, ready_for_snooper); // Drops right after done
		pkt_len[id] = n;
		cpu_q.push_back(id);
		num_pkts++;
	endtask

	task automatic cpu_session(input bit accept);
		int id;
		int k;
		int nb;
		int addr;
		logic [1:0] sz;
		wait_ready(1);
		id = cpu_q.pop_front(); // Oldest packet is the one offered
		check_word("len_to_cpu", pkt_len[id], len_to_cpu);
		for (k = 0; k < 12; k++) begin
			sz = 2'(lcg_next() % 4);
			nb = (sz == 2'd0) ? 1 : (sz == 2'd1) ? 2 : 4;
			addr = lcg_next() % (4 * pkt_len[id] - nb + 1); // Stays inside the packet
			if (k == 0) begin
				sz = sz_half; // Halfword across words 0 and 1
				addr = 3;
			end else if (k == 1) begin
				sz = sz_word; // Word across words 1 and 2
				addr = 6;
			end
			@(posedge clk);
			cpu_byte_rd_addr <= addr[AW+1:0];
			transfer_sz <= sz;
			cpu_rd_en <= 1'b1;
			cpu_exp <= ref_cpu_read(id, addr, sz);
		end
		@(posedge clk);
		cpu_rd_en <= 1'b0;
		@(posedge clk);
		if (accept)
			cpu_acc <= 1'b1;
		else
			cpu_rej <= 1'b1;
		@(posedge clk);
		cpu_acc <= 1'b0;
		cpu_rej <= 1'b0;
		@(negedge clk);
		check_bit("ready_for_cpu", 1'b0, ready_for_cpu);
		if (accept)
			fwd_q.push_back(id); // Rejected packets never enter the forward queue
	endtask

	task automatic fwd_session();
		int id;
		int a;
		wait_ready(2);
		id = fwd_q.pop_front();
		check_word("len_to_forwarder", pkt_len[id], len_to_forwarder);
		for (a = 0; a + 1 < pkt_len[id]; a += 2) begin // Even word addresses
			@(posedge clk);
			forwarder_rd_addr <= a[AW-1:0];
			forwarder_rd_en <= 1'b1;
			fwd_exp <= ref_fwd_read(id, a);
		end
		@(posedge clk);
		forwarder_rd_en <= 1'b0;
		@(posedge clk);
		forwarder_done <= 1'b1;
		@(posedge clk);
		forwarder_done <= 1'b0;
		@(negedge clk);
		check_bit("ready_for_forwarder", 1'b0, ready_for_forwarder);
	endtask

	// Read data is due one cycle after its enable
	always @(posedge clk) begin
		cpu_pend <= cpu_rd_en;
		cpu_exp_q <= cpu_exp;
		fwd_pend <= forwarder_rd_en;
		fwd_exp_q <= fwd_exp;
	end

	always @(negedge clk) begin
		if (cpu_pend)
			check_word("cpu_rd_data", cpu_exp_q, cpu_rd_data);
		if (fwd_pend)
			check_window("forwarder_rd_data", fwd_exp_q, forwarder_rd_data);
	end

	initial begin
		rst = 1'b1;
		snooper_wr_addr = '0;
		snooper_wr_data = '0;
		snooper_wr_en = 1'b0;
		snooper_done = 1'b0;
		cpu_byte_rd_addr = '0;
		transfer_sz = 2'd0;
		cpu_rd_en = 1'b0;
		cpu_rej = 1'b0;
		cpu_acc = 1'b0;
		forwarder_rd_addr = '0;
		forwarder_rd_en = 1'b0;
		forwarder_done = 1'b0;
		cpu_exp = '0;
		fwd_exp = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		check_bit("ready_for_snooper", 1'b0, ready_for_snooper); // All low in reset
		check_bit("ready_for_cpu", 1'b0, ready_for_cpu);
		check_bit("ready_for_forwarder", 1'b0, ready_for_forwarder);
		@(posedge clk);
		rst <= 1'b0;
		wait_ready(0);
		check_bit("ready_for_cpu", 1'b0, ready_for_cpu);
		check_bit("ready_for_forwarder", 1'b0, ready_for_forwarder);
		write_packet(); // One packet straight through
		cpu_session(1'b1);
		fwd_session();
		write_packet(); // First one rejected, second one accepted
		write_packet();
		cpu_session(1'b0);
		cpu_session(1'b1);
		fwd_session();
		write_packet(); // Backlog with CPU and forwarder stalled
		write_packet();
		repeat (16) begin
			@(negedge clk);
			check_bit("ready_for_snooper", 1'b0, ready_for_snooper); // Held by the waiting packet
		end
		cpu_session(1'b1);
		write_packet();
		cpu_session(1'b1);
		fwd_session();
		fwd_session();
		cpu_session(1'b1);
		fwd_session();
		repeat (4) @(posedge clk);
		$display("Closing report: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule
